// ==== build.f ====
common/bus_pkg.sv
common/mem_map_pkg.sv
common/slave_bus_if.sv
sram/sram_slave.sv
interconnect/request_arbiter.sv
interconnect/response_router.sv
rtl/bus_top.sv
tests/bus_props.sv
tests/tb_bus_top.sv

// ==== Bender.yml ====
package:
  name: bus_fabric

sources:
  - files:
      - common/bus_pkg.sv
      - common/mem_map_pkg.sv
      - common/slave_bus_if.sv
      - sram/sram_slave.sv
      - interconnect/request_arbiter.sv
      - interconnect/response_router.sv
      - rtl/bus_top.sv
  - target: test
    files:
      - tests/bus_props.sv
      - tests/tb_bus_top.sv

// ==== tests/tb_bus_top.sv ====
`timescale 1ns/10ps
// Table-driven testbench for the two-master SRAM fabric
// Only addresses that were written before are read back, SRAM is not reset
// Peer requests read the other slave, so their data does not depend on order
// Every wait gives up after TIMEOUT clock cycles
module tb_bus_top;

    import bus_pkg::*;
    import mem_map_pkg::*;

    localparam int TIMEOUT = 50;

    // One table entry
    typedef struct {
        string             name;
        bit                mst;
        bit                wr;
        logic [ADDR_W-1:0] addr;
        logic [STRB_W-1:0] strb;
        bit                conc;
        int                hold;
    } vec_t;

    logic              clk;
    logic              rst_n;
    logic              m0_req_valid;
    logic              m0_req_ready;
    logic [ADDR_W-1:0] m0_req_addr;
    logic              m0_rsp_valid;
    logic              m0_rsp_ready;
    logic [DATA_W-1:0] m0_rsp_rdata;
    logic              m1_req_valid;
    logic              m1_req_ready;
    logic [ADDR_W-1:0] m1_req_addr;
    logic              m1_req_write;
    logic [DATA_W-1:0] m1_req_wdata;
    logic [STRB_W-1:0] m1_req_wstrb;
    logic              m1_rsp_valid;
    logic              m1_rsp_ready;
    logic [DATA_W-1:0] m1_rsp_rdata;

    // Reference memory, indexed by {select, word index}
    logic [DATA_W-1:0] ref_mem [2**(SLAVE_IDX_W+WORD_IDX_W)];
    vec_t              vecs [$];
    vec_t              v;
    bus_addr_u         a;
    bus_addr_u         b;
    logic [31:0]       seed;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] exp_a;
    logic [DATA_W-1:0] exp_b;
    logic [DATA_W-1:0] got_a;
    logic [DATA_W-1:0] got_b;
    int                err_count;
    int                fail_count;
    int                errs_before;

    bus_top #(
        .SRAM_WORDS (1024)
    ) i_bus_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Bytes under the strobe take the new data
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                      input logic [DATA_W-1:0] data,
                                                      input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] res;
        res = old;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = data[8*i +: 8];
            end
        end
        return res;
    endfunction

    // Upper address bits are not part of the key
    function automatic int mem_key(input bus_addr_u addr);
        return int'({addr.fields.sel, addr.fields.word_idx});
    endfunction

    function automatic logic rsp_valid_of(input bit mst);
        return mst ? m1_rsp_valid : m0_rsp_valid;
    endfunction

    function automatic logic [DATA_W-1:0] rsp_rdata_of(input bit mst);
        return mst ? m1_rsp_rdata : m0_rsp_rdata;
    endfunction

    task automatic check_eq(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %08h actual %08h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic add_vec(input string name, input bit mst, input bit wr,
                           input logic [ADDR_W-1:0] addr, input logic [STRB_W-1:0] strb,
                           input bit conc, input int hold);
        vec_t e;
        e.name = name;
        e.mst  = mst;
        e.wr   = wr;
        e.addr = addr;
        e.strb = strb;
        e.conc = conc;
        e.hold = hold;
        vecs.push_back(e);
    endtask

    // ----------------------------------------
    // One transaction on one master
    // ----------------------------------------
    task automatic run_txn(input string name, input bit mst, input bit wr,
                           input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb, input int hold,
                           output logic [DATA_W-1:0] rdata);
        int   cnt;
        logic ok;
        logic [DATA_W-1:0] first;
        rdata = 'x;
        @(negedge clk);
        if (mst) begin
            m1_req_valid = 1'b1;
            m1_req_addr  = addr;
            m1_req_write = wr;
            m1_req_wdata = data;
            m1_req_wstrb = strb;
        end else begin
            m0_req_valid = 1'b1;
            m0_req_addr  = addr;
        end
        // Request handshake, ready seen before the edge updates
        cnt = 0;
        ok  = 1'b0;
        while (!ok && cnt < TIMEOUT) begin
            @(posedge clk);
            ok = mst ? m1_req_ready : m0_req_ready;
            cnt++;
        end
        @(negedge clk);
        if (mst) begin
            m1_req_valid = 1'b0;
        end else begin
            m0_req_valid = 1'b0;
        end
        if (!ok) begin
            $display("Timeout in %s: master %0d request was never accepted", name, mst);
            err_count++;
            return;
        end
        // Response phase
        cnt = 0;
        while (!rsp_valid_of(mst) && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!rsp_valid_of(mst)) begin
            $display("Timeout in %s: master %0d got no response", name, mst);
            err_count++;
            return;
        end
        first = rsp_rdata_of(mst);
        // Back-pressure, response must hold still
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_eq({name, "_hold_valid"}, 1, rsp_valid_of(mst));
            check_eq({name, "_hold_data"}, first, rsp_rdata_of(mst));
        end
        if (mst) begin
            m1_rsp_ready = 1'b1;
        end else begin
            m0_rsp_ready = 1'b1;
        end
        @(posedge clk);
        @(negedge clk);
        m0_rsp_ready = m0_rsp_ready & mst;
        m1_rsp_ready = m1_rsp_ready & ~mst;
        rdata = first;
    endtask

    // ----------------------------------------
    // Stimulus table and main loop
    // ----------------------------------------
    initial begin
        rst_n        = 1'b0;
        m0_req_valid = 1'b0;
        m0_req_addr  = '0;
        m0_rsp_ready = 1'b0;
        m1_req_valid = 1'b0;
        m1_req_addr  = '0;
        m1_req_write = 1'b0;
        m1_req_wdata = '0;
        m1_req_wstrb = '0;
        m1_rsp_ready = 1'b0;
        seed         = 32'hf2d1_89d8;
        err_count    = 0;
        fail_count   = 0;

        //      name            mst   wr    addr           strb   conc  hold
        add_vec("wr_full_s0",   1'b1, 1'b1, 32'h0000_0040, 4'hf, 1'b0, 0);
        add_vec("rd_full_s0",   1'b1, 1'b0, 32'h0000_0040, 4'h0, 1'b0, 0);
        add_vec("wr_full_s1",   1'b1, 1'b1, 32'h0000_1040, 4'hf, 1'b0, 0);
        add_vec("rd_full_s1",   1'b1, 1'b0, 32'h0000_1040, 4'h0, 1'b0, 0);
        add_vec("rd_sep_s0",    1'b1, 1'b0, 32'h0000_0040, 4'h0, 1'b0, 0);
        add_vec("wr_base",      1'b1, 1'b1, 32'h0000_0080, 4'hf, 1'b0, 0);
        add_vec("wr_strb_5",    1'b1, 1'b1, 32'h0000_0080, 4'h5, 1'b0, 0);
        add_vec("rd_strb_5",    1'b1, 1'b0, 32'h0000_0080, 4'h0, 1'b0, 0);
        add_vec("wr_strb_hi",   1'b1, 1'b1, 32'hffff_e080, 4'h8, 1'b0, 0);
        add_vec("wr_base_s1",   1'b1, 1'b1, 32'h0000_1080, 4'hf, 1'b0, 0);
        add_vec("rd_m0_shared", 1'b0, 1'b0, 32'h0000_0080, 4'h0, 1'b0, 0);
        add_vec("rd_m0_s1",     1'b0, 1'b0, 32'h0000_1040, 4'h0, 1'b0, 0);
        add_vec("conc_m0",      1'b0, 1'b0, 32'h0000_0040, 4'h0, 1'b1, 0);
        add_vec("conc_m1",      1'b1, 1'b0, 32'h0000_0080, 4'h0, 1'b1, 0);
        add_vec("conc_wr",      1'b1, 1'b1, 32'h0000_1040, 4'h3, 1'b1, 0);
        add_vec("bp_m1",        1'b1, 1'b0, 32'h0000_1040, 4'h0, 1'b0, 5);
        add_vec("bp_m0",        1'b0, 1'b0, 32'h0000_0080, 4'h0, 1'b0, 4);
        add_vec("after_bp",     1'b1, 1'b0, 32'h0000_0040, 4'h0, 1'b0, 0);

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        foreach (vecs[i]) begin
            v           = vecs[i];
            errs_before = err_count;
            a.raw       = v.addr;
            wdata       = '0;
            if (v.wr) begin
                seed  = lcg_next(seed);
                wdata = seed;
            end
            // Writes answer with zero data
            exp_a = v.wr ? '0 : ref_mem[mem_key(a)];
            if (v.conc) begin
                b.raw = v.addr ^ (32'd1 << SEL_LSB);
                exp_b = ref_mem[mem_key(b)];
                fork
                    run_txn(v.name, v.mst, v.wr, a.raw, wdata, v.strb, v.hold, got_a);
                    run_txn({v.name, "_peer"}, ~v.mst, 1'b0, b.raw, '0, '0, 0, got_b);
                join
                check_eq({v.name, "_peer"}, exp_b, got_b);
            end else begin
                run_txn(v.name, v.mst, v.wr, a.raw, wdata, v.strb, v.hold, got_a);
            end
            check_eq(v.name, exp_a, got_a);
            if (v.wr) begin
                ref_mem[mem_key(a)] = merge_bytes(ref_mem[mem_key(a)], wdata, v.strb);
            end
            if (err_count == errs_before) begin
                $display("%-14s pass", v.name);
            end else begin
                $display("%-14s fail", v.name);
                fail_count++;
            end
        end

        err_count += i_bus_top.i_bus_props.fail_cnt;
        $display("tests %0d, failed %0d, errors %0d", vecs.size(), fail_count, err_count);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/bus_props.sv ====
`timescale 1ns/10ps
// Handshake properties on the master ports of bus_top
// Sampled on the rising edge, stability checks are off during reset
module bus_props
    import bus_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic              m0_req_valid,
    input logic              m0_req_ready,
    input logic [ADDR_W-1:0] m0_req_addr,
    input logic              m0_rsp_valid,
    input logic              m0_rsp_ready,
    input logic [DATA_W-1:0] m0_rsp_rdata,
    input logic              m1_req_valid,
    input logic              m1_req_ready,
    input logic [ADDR_W-1:0] m1_req_addr,
    input logic              m1_req_write,
    input logic [DATA_W-1:0] m1_req_wdata,
    input logic [STRB_W-1:0] m1_req_wstrb,
    input logic              m1_rsp_valid,
    input logic              m1_rsp_ready,
    input logic [DATA_W-1:0] m1_rsp_rdata
);

    // Number of failed properties so far
    int unsigned fail_cnt;

    // ----------------------------------------
    // Valid holds with stable payload
    // ----------------------------------------
    assert property (@(posedge clk) disable iff (!rst_n)
        m0_req_valid && !m0_req_ready |=> m0_req_valid && $stable(m0_req_addr))
        else begin
            $error("m0 request dropped or changed before ready");
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        m1_req_valid && !m1_req_ready |=> m1_req_valid
            && $stable({m1_req_addr, m1_req_write, m1_req_wdata, m1_req_wstrb}))
        else begin
            $error("m1 request dropped or changed before ready");
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        m0_rsp_valid && !m0_rsp_ready |=> m0_rsp_valid && $stable(m0_rsp_rdata))
        else begin
            $error("m0 response dropped or changed before ready");
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        m1_rsp_valid && !m1_rsp_ready |=> m1_rsp_valid && $stable(m1_rsp_rdata))
        else begin
            $error("m1 response dropped or changed before ready");
            fail_cnt++;
        end

    // Quiet in reset, one response at a time
    assert property (@(posedge clk) !rst_n |-> !m0_rsp_valid && !m1_rsp_valid)
        else begin
            $error("response valid during reset");
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) !(m0_rsp_valid && m1_rsp_valid))
        else begin
            $error("both masters see a response");
            fail_cnt++;
        end

endmodule

bind bus_top bus_props i_bus_props (.*);

// ==== rtl/bus_top.sv ====
`timescale 1ns/10ps
// Two-master, two-SRAM shared memory fabric
// One transaction open at a time, round-robin between the masters
// m0 is read only, m1 reads and writes with byte strobes
// Address bit 12 selects the slave, bits above it are ignored
module bus_top
    import bus_pkg::*, mem_map_pkg::*;
#(
    // Depth of each SRAM in words
    parameter int SRAM_WORDS = 1024
) (
    input  logic              clk,
    input  logic              rst_n,

    // Master 0 request, instruction fetch
    input  logic              m0_req_valid,
    output logic              m0_req_ready,
    input  logic [ADDR_W-1:0] m0_req_addr,
    // Master 0 response
    output logic              m0_rsp_valid,
    input  logic              m0_rsp_ready,
    output logic [DATA_W-1:0] m0_rsp_rdata,

    // Master 1 request, data port
    input  logic              m1_req_valid,
    output logic              m1_req_ready,
    input  logic [ADDR_W-1:0] m1_req_addr,
    input  logic              m1_req_write,
    input  logic [DATA_W-1:0] m1_req_wdata,
    input  logic [STRB_W-1:0] m1_req_wstrb,
    // Master 1 response
    output logic              m1_rsp_valid,
    input  logic              m1_rsp_ready,
    output logic [DATA_W-1:0] m1_rsp_rdata
);

    // Ownership of the open transaction
    master_idx_t owner_master;
    slave_idx_t  owner_slave;
    logic        txn_done;

    // One bus per SRAM
    slave_bus_if slv_bus [N_SLAVES] ();

    // ----------------------------------------
    // Request side
    // ----------------------------------------
    request_arbiter i_request_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .m0_req_valid (m0_req_valid),
        .m0_req_ready (m0_req_ready),
        .m0_req_addr  (m0_req_addr),
        .m1_req_valid (m1_req_valid),
        .m1_req_ready (m1_req_ready),
        .m1_req_write (m1_req_write),
        .m1_req_addr  (m1_req_addr),
        .m1_req_wdata (m1_req_wdata),
        .m1_req_wstrb (m1_req_wstrb),
        .slv          (slv_bus),
        .owner_master (owner_master),
        .owner_slave  (owner_slave),
        .txn_done     (txn_done)
    );

    // Identical memories, slave index equals the select value
    for (genvar g = 0; g < N_SLAVES; g++) begin : g_sram
        sram_slave #(
            .WORDS (SRAM_WORDS)
        ) i_sram_slave (
            .clk   (clk),
            .rst_n (rst_n),
            .bus   (slv_bus[g].target)
        );
    end

    // ----------------------------------------
    // Response side
    // ----------------------------------------
    response_router i_response_router (
        .slv          (slv_bus),
        .owner_master (owner_master),
        .owner_slave  (owner_slave),
        .m0_rsp_valid (m0_rsp_valid),
        .m0_rsp_rdata (m0_rsp_rdata),
        .m0_rsp_ready (m0_rsp_ready),
        .m1_rsp_valid (m1_rsp_valid),
        .m1_rsp_rdata (m1_rsp_rdata),
        .m1_rsp_ready (m1_rsp_ready),
        .txn_done     (txn_done)
    );

endmodule

// ==== interconnect/response_router.sv ====
`timescale 1ns/10ps
// Returns the owning slave's response to the owning master
// Purely combinational, ownership comes registered from the arbiter
// Only the owning slave ever sees the master's rsp_ready
module response_router
    import bus_pkg::*, mem_map_pkg::*;
(
    // Slave response channels
    slave_bus_if.initiator    slv [N_SLAVES],
    input  master_idx_t       owner_master,
    input  slave_idx_t        owner_slave,
    // Master 0 response
    output logic              m0_rsp_valid,
    output logic [DATA_W-1:0] m0_rsp_rdata,
    input  logic              m0_rsp_ready,
    // Master 1 response
    output logic              m1_rsp_valid,
    output logic [DATA_W-1:0] m1_rsp_rdata,
    input  logic              m1_rsp_ready,
    // Pulse on the completing response handshake
    output logic              txn_done
);

    logic [N_SLAVES-1:0] slv_rsp_valid;
    logic [DATA_W-1:0]   slv_rsp_rdata [N_SLAVES];
    logic                sel_valid;
    logic [DATA_W-1:0]   sel_rdata;
    logic                to_m1;
    logic                mst_ready;

    // Gather slave responses, steer ready back to the owner only
    for (genvar i = 0; i < N_SLAVES; i++) begin : g_slv
        assign slv_rsp_valid[i] = slv[i].rsp_valid;
        assign slv_rsp_rdata[i] = slv[i].rsp_rdata;
        assign slv[i].rsp_ready = (owner_slave == slave_idx_t'(i)) & mst_ready;
    end

    // Owning slave's response
    assign sel_valid = slv_rsp_valid[owner_slave];
    assign sel_rdata = slv_rsp_rdata[owner_slave];

    // Owning master's side
    assign to_m1     = (owner_master == master_idx_t'(1));
    assign mst_ready = to_m1 ? m1_rsp_ready : m0_rsp_ready;

    assign m0_rsp_valid = sel_valid & ~to_m1;
    assign m1_rsp_valid = sel_valid & to_m1;
    // Data only counts with valid, so both see it
    assign m0_rsp_rdata = sel_rdata;
    assign m1_rsp_rdata = sel_rdata;

    assign txn_done = sel_valid & mst_ready;

endmodule

// ==== interconnect/request_arbiter.sv ====
`timescale 1ns/10ps
// Round-robin arbiter for the two masters, one transaction outstanding
// Grant is combinational in the master handshake cycle
// Slave request is registered, so it appears one cycle after the grant
// No new grant until the response router signals txn_done
module request_arbiter
    import bus_pkg::*, mem_map_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    // Master 0 request, always issued as a read
    input  logic              m0_req_valid,
    output logic              m0_req_ready,
    input  logic [ADDR_W-1:0] m0_req_addr,
    // Master 1 request
    input  logic              m1_req_valid,
    output logic              m1_req_ready,
    input  logic              m1_req_write,
    input  logic [ADDR_W-1:0] m1_req_addr,
    input  logic [DATA_W-1:0] m1_req_wdata,
    input  logic [STRB_W-1:0] m1_req_wstrb,
    // Slave request channels
    slave_bus_if.initiator    slv [N_SLAVES],
    // Owner of the open transaction, registered at grant
    output master_idx_t       owner_master,
    output slave_idx_t        owner_slave,
    // Response handshake of the owner completed
    input  logic              txn_done
);

    logic                busy_q;
    // Master favored on the next tie
    master_idx_t         rr_q;
    logic                pick_m1;
    logic                gnt;
    master_idx_t         gnt_idx;
    bus_addr_u           gnt_addr;
    logic [N_SLAVES-1:0] slv_valid_q;
    logic [N_SLAVES-1:0] slv_ready;
    // Registered request payload, shared by all slaves
    bus_addr_u           addr_q;
    logic                write_q;
    logic [DATA_W-1:0]   wdata_q;
    logic [STRB_W-1:0]   wstrb_q;

    // ----------------------------------------
    // Master selection
    // ----------------------------------------

    // m1 wins when alone or when it holds the pointer
    assign pick_m1 = m1_req_valid & (~m0_req_valid | (rr_q == master_idx_t'(1)));
    assign gnt     = ~busy_q & (m0_req_valid | m1_req_valid);
    assign gnt_idx = pick_m1 ? master_idx_t'(1) : master_idx_t'(0);

    assign m0_req_ready = gnt & ~pick_m1;
    assign m1_req_ready = gnt & pick_m1;

    // Decode view of the winning address
    assign gnt_addr.raw = pick_m1 ? m1_req_addr : m0_req_addr;

    // ----------------------------------------
    // Transaction state
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q       <= 1'b0;
            rr_q         <= '0;
            owner_master <= '0;
            owner_slave  <= '0;
            slv_valid_q  <= '0;
        end else begin
            // Each slave request drops once taken
            slv_valid_q <= slv_valid_q & ~slv_ready;
            if (gnt) begin
                busy_q       <= 1'b1;
                // Other master goes first next time
                rr_q         <= ~gnt_idx;
                owner_master <= gnt_idx;
                owner_slave  <= gnt_addr.fields.sel;
                slv_valid_q  <= N_SLAVES'(1) << gnt_addr.fields.sel;
            end else if (txn_done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Payload captured at grant, m0 forced to a plain read
    always_ff @(posedge clk) begin
        if (gnt) begin
            addr_q  <= gnt_addr;
            write_q <= pick_m1 & m1_req_write;
            wdata_q <= pick_m1 ? m1_req_wdata : '0;
            wstrb_q <= pick_m1 ? m1_req_wstrb : '0;
        end
    end

    // Fan the registered request out to every slave
    for (genvar i = 0; i < N_SLAVES; i++) begin : g_slv
        assign slv[i].req_valid = slv_valid_q[i];
        assign slv[i].req_write = write_q;
        assign slv[i].req_addr  = addr_q;
        assign slv[i].req_wdata = wdata_q;
        assign slv[i].req_wstrb = wstrb_q;
        assign slv_ready[i]     = slv[i].req_ready;
    end

endmodule

// ==== sram/sram_slave.sv ====
`timescale 1ns/10ps
// Single-port SRAM behind a valid/ready request and response channel
// Request is registered, the access happens one cycle later
// Writes merge bytes under the strobes and answer with zero data
// WORDS below 1024 leaves the upper word indexes unmapped
module sram_slave
    import bus_pkg::*, mem_map_pkg::*;
#(
    parameter int WORDS = 1024
) (
    input  logic        clk,
    input  logic        rst_n,
    slave_bus_if.target bus
);

    logic [DATA_W-1:0] mem [WORDS];
    // Request taken, access in the next cycle
    logic              pend_q;
    logic              rsp_valid_q;
    logic              req_ready;
    logic              req_fire;
    // Captured request
    bus_addr_u         cmd_addr_q;
    logic              cmd_write_q;
    logic [DATA_W-1:0] cmd_wdata_q;
    logic [STRB_W-1:0] cmd_wstrb_q;
    logic [DATA_W-1:0] rdata_q;

    // Accept only with nothing in flight or waiting
    assign req_ready = ~pend_q & ~rsp_valid_q;
    assign req_fire  = bus.req_valid & req_ready;

    assign bus.req_ready = req_ready;
    assign bus.rsp_valid = rsp_valid_q;
    assign bus.rsp_rdata = rdata_q;

    // ----------------------------------------
    // Handshake control
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q      <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            pend_q <= req_fire;
            if (pend_q) begin
                rsp_valid_q <= 1'b1;
            end else if (rsp_valid_q && bus.rsp_ready) begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Storage and read data
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (req_fire) begin
            cmd_addr_q  <= bus.req_addr;
            cmd_write_q <= bus.req_write;
            cmd_wdata_q <= bus.req_wdata;
            cmd_wstrb_q <= bus.req_wstrb;
        end
        // Response register only moves while no response is held
        if (pend_q) begin
            if (cmd_write_q) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (cmd_wstrb_q[b]) begin
                        mem[cmd_addr_q.fields.word_idx][8*b +: 8] <= cmd_wdata_q[8*b +: 8];
                    end
                end
            end
            rdata_q <= cmd_write_q ? '0 : mem[cmd_addr_q.fields.word_idx];
        end
    end

endmodule

// ==== common/slave_bus_if.sv ====
`timescale 1ns/10ps
// Request and response channels between the fabric and one SRAM slave
// Both channels use valid/ready, a transfer happens when both are high
// Valid holds with stable payload until taken and never waits for ready
// Request side is driven by the arbiter, rsp_ready by the response router
interface slave_bus_if
    import bus_pkg::*, mem_map_pkg::*;
();

    // ----------------------------------------
    // Request channel
    // ----------------------------------------
    logic              req_valid;
    logic              req_ready;
    logic              req_write;
    bus_addr_u         req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic [STRB_W-1:0] req_wstrb;

    // ----------------------------------------
    // Response channel
    // ----------------------------------------
    logic              rsp_valid;
    logic              rsp_ready;
    // Zero for writes
    logic [DATA_W-1:0] rsp_rdata;

    // Fabric side
    modport initiator (
        output req_valid, req_write, req_addr, req_wdata, req_wstrb, rsp_ready,
        input  req_ready, rsp_valid, rsp_rdata
    );

    // Memory side
    modport target (
        input  req_valid, req_write, req_addr, req_wdata, req_wstrb, rsp_ready,
        output req_ready, rsp_valid, rsp_rdata
    );

endinterface

// ==== common/mem_map_pkg.sv ====
// Address map of the SRAM slaves and the decode view of a bus address
// One select bit picks the slave, upper address bits are not decoded
// Word index covers 1024 words per slave, byte offset is never used
package mem_map_pkg;

    import bus_pkg::*;

    // ----------------------------------------
    // Slave map
    // ----------------------------------------

    localparam int N_SLAVES    = 2;
    localparam int SLAVE_IDX_W = $clog2(N_SLAVES);

    // Byte lanes inside one word
    localparam int BYTE_OFF_W  = $clog2(STRB_W);

    // 1024 words of DATA_W bits per SRAM
    localparam int WORD_IDX_W  = 10;

    // Select sits right above the word index, bit 12
    localparam int SEL_LSB     = WORD_IDX_W + BYTE_OFF_W;

    typedef logic [SLAVE_IDX_W-1:0] slave_idx_t;

    // Field view of the address, high to low
    typedef struct packed {
        logic [ADDR_W-SEL_LSB-SLAVE_IDX_W-1:0] unused;
        slave_idx_t                            sel;
        logic [WORD_IDX_W-1:0]                 word_idx;
        logic [BYTE_OFF_W-1:0]                 byte_off;
    } bus_addr_fields_t;

    // Same word, raw or decoded
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        bus_addr_fields_t  fields;
    } bus_addr_u;

endpackage

// ==== common/bus_pkg.sv ====
// Bus widths and master indexing shared by the fabric and the testbench
// Byte strobes assume 8-bit lanes, so DATA_W must be a multiple of 8
// Two masters only, the round-robin pointer relies on that pairing
package bus_pkg;

    // ----------------------------------------
    // Data path widths
    // ----------------------------------------

    // Byte address, bits above the slave select are ignored
    localparam int ADDR_W = 32;

    // One bus word per transaction, no bursts
    localparam int DATA_W = 32;

    // One strobe bit per byte lane
    localparam int STRB_W = DATA_W / 8;

    // ----------------------------------------
    // Masters
    // ----------------------------------------

    // m0 instruction fetch (read only), m1 data port
    localparam int N_MASTERS = 2;

    // Which master owns the open transaction
    typedef logic [$clog2(N_MASTERS)-1:0] master_idx_t;

endpackage
